// File: src/soc_bus_pkg.sv
package soc_bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;

    // AXI-lite style response codes
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;
    localparam resp_t RESP_DECERR = 2'b11;

    // address map
    localparam addr_t SRAM_BASE      = 32'h8000_0000;
    localparam addr_t UART_ADDR      = 32'ha000_03f8; // write sends a byte and read gives status
    localparam addr_t CLINT_MTIME_LO = 32'ha000_0048;
    localparam addr_t CLINT_MTIME_HI = 32'ha000_004c;

    // routing target picked by the crossbar decode
    typedef enum logic [1:0] {
        SEL_SRAM  = 2'd0,
        SEL_UART  = 2'd1,
        SEL_CLINT = 2'd2,
        SEL_NONE  = 2'd3
    } slave_sel_t;

    // master to slave, read side
    typedef struct packed {
        addr_t araddr;
        logic  arvalid;
        logic  rready;
    } rd_req_t;

    // slave to master, read side
    typedef struct packed {
        logic  arready;
        logic  rvalid;
        data_t rdata;
        resp_t rresp;
    } rd_rsp_t;

    // master to slave, write side
    typedef struct packed {
        addr_t awaddr;
        logic  awvalid;
        data_t wdata;
        logic  wvalid;
        logic  bready;
    } wr_req_t;

    // slave to master, write side
    typedef struct packed {
        logic  awready;
        logic  wready;
        logic  bvalid;
        resp_t bresp;
    } wr_rsp_t;

endpackage

// File: src/bus_xbar.sv
`timescale 1ns/1ps

module bus_xbar import soc_bus_pkg::*; #(
    parameter int SRAM_AW = 10
) (
    input  logic    clk,
    input  logic    rst,
    // masters
    input  rd_req_t ifu_rd_req,
    output rd_rsp_t ifu_rd_rsp,
    input  rd_req_t lsu_rd_req,
    output rd_rsp_t lsu_rd_rsp,
    input  wr_req_t lsu_wr_req,
    output wr_rsp_t lsu_wr_rsp,
    // slaves
    output rd_req_t sram_rd_req,
    input  rd_rsp_t sram_rd_rsp,
    output wr_req_t sram_wr_req,
    input  wr_rsp_t sram_wr_rsp,
    output rd_req_t uart_rd_req,
    input  rd_rsp_t uart_rd_rsp,
    output wr_req_t uart_wr_req,
    input  wr_rsp_t uart_wr_rsp,
    output rd_req_t clint_rd_req,
    input  rd_rsp_t clint_rd_rsp,
    output wr_req_t clint_wr_req,
    input  wr_rsp_t clint_wr_rsp
);

    // one-hot grant bits
    localparam int G_IDLE   = 0;
    localparam int G_IFU_RD = 1;
    localparam int G_LSU_RD = 2;
    localparam int G_LSU_WR = 3;

    logic [3:0] grant;
    logic       drain;      // one dead cycle after each transaction
    slave_sel_t sel;
    logic       dec_resp;   // decode-error response pending

    logic    is_rd;
    logic    is_wr;
    rd_req_t mst_rd_req;
    rd_rsp_t slv_rd_rsp;
    wr_rsp_t slv_wr_rsp;
    rd_rsp_t dec_rd_rsp;
    wr_rsp_t dec_wr_rsp;
    logic    dec_accept;
    logic    rd_done;
    logic    wr_done;

    function automatic slave_sel_t decode(input addr_t addr);
        if (addr[31:SRAM_AW+2] == SRAM_BASE[31:SRAM_AW+2]) begin
            return SEL_SRAM;
        end
        if (addr == UART_ADDR) begin
            return SEL_UART;
        end
        if (addr == CLINT_MTIME_LO || addr == CLINT_MTIME_HI) begin
            return SEL_CLINT;
        end
        return SEL_NONE;
    endfunction

    // priority order is ifu read then lsu read then lsu write
    always_ff @(posedge clk) begin
        if (rst) begin
            grant <= 4'b0001;
            drain <= 1'b0;
            sel   <= SEL_NONE;
        end else if (grant[G_IDLE]) begin
            if (drain) begin
                drain <= 1'b0;
            end else if (ifu_rd_req.arvalid) begin
                grant <= 4'b0010;
                sel   <= decode(ifu_rd_req.araddr);
            end else if (lsu_rd_req.arvalid) begin
                grant <= 4'b0100;
                sel   <= decode(lsu_rd_req.araddr);
            end else if (lsu_wr_req.awvalid && lsu_wr_req.wvalid) begin
                grant <= 4'b1000;
                sel   <= decode(lsu_wr_req.awaddr);
            end
        end else if (rd_done || wr_done) begin
            grant <= 4'b0001;
            drain <= 1'b1;
        end
    end

    // decode-error responder answers one cycle after accepting
    always_comb begin
        dec_rd_rsp         = '0;
        dec_rd_rsp.arready = !dec_resp;
        dec_rd_rsp.rvalid  = dec_resp;
        dec_rd_rsp.rresp   = RESP_DECERR; // rdata stays 0

        dec_wr_rsp         = '0;
        dec_wr_rsp.awready = !dec_resp && lsu_wr_req.awvalid && lsu_wr_req.wvalid;
        dec_wr_rsp.wready  = dec_wr_rsp.awready;
        dec_wr_rsp.bvalid  = dec_resp;
        dec_wr_rsp.bresp   = RESP_DECERR;
    end

    assign dec_accept = (sel == SEL_NONE) &&
                        ((is_rd && mst_rd_req.arvalid && dec_rd_rsp.arready) ||
                         (is_wr && dec_wr_rsp.awready));

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_resp <= 1'b0;
        end else if (rd_done || wr_done) begin
            dec_resp <= 1'b0;
        end else if (dec_accept) begin
            dec_resp <= 1'b1;
        end
    end

    // router
    always_comb begin
        is_rd      = grant[G_IFU_RD] | grant[G_LSU_RD];
        is_wr      = grant[G_LSU_WR];
        mst_rd_req = grant[G_IFU_RD] ? ifu_rd_req : lsu_rd_req;

        sram_rd_req  = '0;
        uart_rd_req  = '0;
        clint_rd_req = '0;
        sram_wr_req  = '0;
        uart_wr_req  = '0;
        clint_wr_req = '0;
        slv_rd_rsp   = '0;
        slv_wr_rsp   = '0;

        if (is_rd) begin
            case (sel)
                SEL_SRAM: begin
                    sram_rd_req = mst_rd_req;
                    slv_rd_rsp  = sram_rd_rsp;
                end
                SEL_UART: begin
                    uart_rd_req = mst_rd_req;
                    slv_rd_rsp  = uart_rd_rsp;
                end
                SEL_CLINT: begin
                    clint_rd_req = mst_rd_req;
                    slv_rd_rsp   = clint_rd_rsp;
                end
                default: slv_rd_rsp = dec_rd_rsp;
            endcase
        end

        if (is_wr) begin
            case (sel)
                SEL_SRAM: begin
                    sram_wr_req = lsu_wr_req;
                    slv_wr_rsp  = sram_wr_rsp;
                end
                SEL_UART: begin
                    uart_wr_req = lsu_wr_req;
                    slv_wr_rsp  = uart_wr_rsp;
                end
                SEL_CLINT: begin
                    clint_wr_req = lsu_wr_req;
                    slv_wr_rsp   = clint_wr_rsp;
                end
                default: slv_wr_rsp = dec_wr_rsp;
            endcase
        end

        ifu_rd_rsp = grant[G_IFU_RD] ? slv_rd_rsp : '0;
        lsu_rd_rsp = grant[G_LSU_RD] ? slv_rd_rsp : '0;
        lsu_wr_rsp = is_wr ? slv_wr_rsp : '0;
    end

    // end of transaction on r or b handshake
    assign rd_done = is_rd && slv_rd_rsp.rvalid && mst_rd_req.rready;
    assign wr_done = is_wr && slv_wr_rsp.bvalid && lsu_wr_req.bready;

endmodule

// File: src/sram_slave.sv
`timescale 1ns/1ps

module sram_slave import soc_bus_pkg::*; #(
    parameter int SRAM_AW = 10
) (
    input  logic    clk,
    input  logic    rst,
    input  rd_req_t rd_req,
    output rd_rsp_t rd_rsp,
    input  wr_req_t wr_req,
    output wr_rsp_t wr_rsp
);

    data_t mem [2**SRAM_AW];

    logic  rvalid_q;
    data_t rdata_q;
    logic  bvalid_q;
    logic  ar_hs;
    logic  aw_hs;

    assign ar_hs = rd_req.arvalid && rd_rsp.arready;
    assign aw_hs = wr_rsp.awready && wr_rsp.wready;

    always_comb begin
        rd_rsp.arready = !rvalid_q;   // idle
        rd_rsp.rvalid  = rvalid_q;
        rd_rsp.rdata   = rdata_q;
        rd_rsp.rresp   = RESP_OKAY;

        // aw and w only accepted together
        wr_rsp.awready = wr_req.awvalid && wr_req.wvalid && !bvalid_q;
        wr_rsp.wready  = wr_rsp.awready;
        wr_rsp.bvalid  = bvalid_q;
        wr_rsp.bresp   = RESP_OKAY;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (ar_hs) begin
                rvalid_q <= 1'b1;
            end else if (rd_req.rready) begin
                rvalid_q <= 1'b0;
            end
            if (aw_hs) begin
                bvalid_q <= 1'b1;
            end else if (wr_req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    // word-indexed memory port
    always_ff @(posedge clk) begin
        if (aw_hs) begin
            mem[wr_req.awaddr[SRAM_AW+1:2]] <= wr_req.wdata;
        end else if (ar_hs) begin
            rdata_q <= mem[rd_req.araddr[SRAM_AW+1:2]];
        end
    end

endmodule

// File: src/uart_tx_slave.sv
`timescale 1ns/1ps

module uart_tx_slave import soc_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  rd_req_t    rd_req,
    output rd_rsp_t    rd_rsp,
    input  wr_req_t    wr_req,
    output wr_rsp_t    wr_rsp,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready
);

    logic       pending;    // byte waiting for tx_ready
    logic [7:0] tx_byte;
    logic       rvalid_q;
    logic       busy_q;     // status sampled at the ar transfer
    logic       bvalid_q;

    assign tx_data  = tx_byte;
    assign tx_valid = pending;

    always_comb begin
        rd_rsp.arready = !rvalid_q;
        rd_rsp.rvalid  = rvalid_q;
        rd_rsp.rdata   = {31'b0, busy_q};
        rd_rsp.rresp   = RESP_OKAY;

        // no new byte until the pending one has left
        wr_rsp.awready = wr_req.awvalid && wr_req.wvalid && !pending && !bvalid_q;
        wr_rsp.wready  = wr_rsp.awready;
        wr_rsp.bvalid  = bvalid_q;
        wr_rsp.bresp   = RESP_OKAY;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pending  <= 1'b0;
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            if (wr_rsp.awready) begin
                pending  <= 1'b1;
                bvalid_q <= 1'b1;
            end else begin
                if (tx_ready) pending <= 1'b0;
                if (wr_req.bready) bvalid_q <= 1'b0;
            end
            if (rd_req.arvalid && rd_rsp.arready) rvalid_q <= 1'b1;
            else if (rd_req.rready) rvalid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_rsp.awready) tx_byte <= wr_req.wdata[7:0]; // low byte only
        if (rd_req.arvalid && rd_rsp.arready) busy_q <= pending;
    end

endmodule

// File: src/clint_timer.sv
`timescale 1ns/1ps

module clint_timer import soc_bus_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  rd_req_t rd_req,
    output rd_rsp_t rd_rsp,
    input  wr_req_t wr_req,
    output wr_rsp_t wr_rsp
);

    logic [63:0] mtime;
    logic        rvalid_q;
    data_t       rdata_q;
    logic        bvalid_q;
    logic        ar_hs;

    assign ar_hs = rd_req.arvalid && rd_rsp.arready;

    always_comb begin
        rd_rsp.arready = !rvalid_q;
        rd_rsp.rvalid  = rvalid_q;
        rd_rsp.rdata   = rdata_q;
        rd_rsp.rresp   = RESP_OKAY;

        // mtime is read-only here so writes are refused
        wr_rsp.awready = wr_req.awvalid && wr_req.wvalid && !bvalid_q;
        wr_rsp.wready  = wr_rsp.awready;
        wr_rsp.bvalid  = bvalid_q;
        wr_rsp.bresp   = RESP_SLVERR;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtime    <= '0;
            rvalid_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1; // free running
            if (ar_hs) rvalid_q <= 1'b1;
            else if (rd_req.rready) rvalid_q <= 1'b0;
            if (wr_rsp.awready) bvalid_q <= 1'b1;
            else if (wr_req.bready) bvalid_q <= 1'b0;
        end
    end

    // word picked by address and sampled at the ar transfer
    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rdata_q <= (rd_req.araddr == CLINT_MTIME_HI) ? mtime[63:32] : mtime[31:0];
        end
    end

endmodule

// File: src/soc_bus_top.sv
`timescale 1ns/1ps

module soc_bus_top import soc_bus_pkg::*; #(
    parameter int SRAM_AW = 10
) (
    input  logic       clk,
    input  logic       rst,
    input  rd_req_t    ifu_rd_req,
    output rd_rsp_t    ifu_rd_rsp,
    input  rd_req_t    lsu_rd_req,
    output rd_rsp_t    lsu_rd_rsp,
    input  wr_req_t    lsu_wr_req,
    output wr_rsp_t    lsu_wr_rsp,
    output logic [7:0] tx_data,
    output logic       tx_valid,
    input  logic       tx_ready
);

    rd_req_t sram_rd_req;
    rd_rsp_t sram_rd_rsp;
    wr_req_t sram_wr_req;
    wr_rsp_t sram_wr_rsp;
    rd_req_t uart_rd_req;
    rd_rsp_t uart_rd_rsp;
    wr_req_t uart_wr_req;
    wr_rsp_t uart_wr_rsp;
    rd_req_t clint_rd_req;
    rd_rsp_t clint_rd_rsp;
    wr_req_t clint_wr_req;
    wr_rsp_t clint_wr_rsp;

    bus_xbar #(
        .SRAM_AW(SRAM_AW)
    ) u_xbar (
        .clk          (clk),
        .rst          (rst),
        .ifu_rd_req   (ifu_rd_req),
        .ifu_rd_rsp   (ifu_rd_rsp),
        .lsu_rd_req   (lsu_rd_req),
        .lsu_rd_rsp   (lsu_rd_rsp),
        .lsu_wr_req   (lsu_wr_req),
        .lsu_wr_rsp   (lsu_wr_rsp),
        .sram_rd_req  (sram_rd_req),
        .sram_rd_rsp  (sram_rd_rsp),
        .sram_wr_req  (sram_wr_req),
        .sram_wr_rsp  (sram_wr_rsp),
        .uart_rd_req  (uart_rd_req),
        .uart_rd_rsp  (uart_rd_rsp),
        .uart_wr_req  (uart_wr_req),
        .uart_wr_rsp  (uart_wr_rsp),
        .clint_rd_req (clint_rd_req),
        .clint_rd_rsp (clint_rd_rsp),
        .clint_wr_req (clint_wr_req),
        .clint_wr_rsp (clint_wr_rsp)
    );

    sram_slave #(
        .SRAM_AW(SRAM_AW)
    ) u_sram (
        .clk    (clk),
        .rst    (rst),
        .rd_req (sram_rd_req),
        .rd_rsp (sram_rd_rsp),
        .wr_req (sram_wr_req),
        .wr_rsp (sram_wr_rsp)
    );

    uart_tx_slave u_uart (
        .clk      (clk),
        .rst      (rst),
        .rd_req   (uart_rd_req),
        .rd_rsp   (uart_rd_rsp),
        .wr_req   (uart_wr_req),
        .wr_rsp   (uart_wr_rsp),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready)
    );

    clint_timer u_clint (
        .clk    (clk),
        .rst    (rst),
        .rd_req (clint_rd_req),
        .rd_rsp (clint_rd_rsp),
        .wr_req (clint_wr_req),
        .wr_rsp (clint_wr_rsp)
    );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD       = 40,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // released 1 ns after an edge like the other inputs
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
    end

endmodule

// File: testbench/bus_checker.sv
`timescale 1ns/1ps

module bus_checker import soc_bus_pkg::*; (
    input logic    clk,
    input logic    rst,
    input rd_req_t ifu_rd_req,
    input rd_rsp_t ifu_rd_rsp,
    input rd_req_t lsu_rd_req,
    input rd_rsp_t lsu_rd_rsp,
    input wr_req_t lsu_wr_req,
    input wr_rsp_t lsu_wr_rsp,
    input rd_req_t sram_rd_req,
    input rd_req_t uart_rd_req,
    input rd_req_t clint_rd_req,
    input wr_req_t sram_wr_req,
    input wr_req_t uart_wr_req,
    input wr_req_t clint_wr_req
);

    logic [5:0] slave_valid;

    assign slave_valid = {sram_rd_req.arvalid, uart_rd_req.arvalid, clint_rd_req.arvalid,
                          sram_wr_req.awvalid, uart_wr_req.awvalid, clint_wr_req.awvalid};

    one_slave: assert property (@(posedge clk) disable iff (rst) $onehot0(slave_valid))
        else $error("more than one slave sees a valid request");

    // masters hold valid until the transfer
    ifu_ar_hold: assert property (@(posedge clk) disable iff (rst)
        ifu_rd_req.arvalid && !ifu_rd_rsp.arready |=> ifu_rd_req.arvalid)
        else $error("ifu arvalid dropped before arready");
    lsu_ar_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_rd_req.arvalid && !lsu_rd_rsp.arready |=> lsu_rd_req.arvalid)
        else $error("lsu arvalid dropped before arready");
    lsu_aw_hold: assert property (@(posedge clk) disable iff (rst)
        lsu_wr_req.awvalid && !lsu_wr_rsp.awready |=> lsu_wr_req.awvalid && lsu_wr_req.wvalid)
        else $error("lsu awvalid or wvalid dropped before awready");

    reset_quiet: assert property (@(posedge clk)
        rst |=> ({ifu_rd_rsp, lsu_rd_rsp, lsu_wr_rsp} == '0 &&
                 {sram_rd_req, uart_rd_req, clint_rd_req} == '0 &&
                 {sram_wr_req, uart_wr_req, clint_wr_req} == '0))
        else $error("crossbar outputs not low in reset");

endmodule

bind bus_xbar bus_checker u_checker (
    .clk          (clk),
    .rst          (rst),
    .ifu_rd_req   (ifu_rd_req),
    .ifu_rd_rsp   (ifu_rd_rsp),
    .lsu_rd_req   (lsu_rd_req),
    .lsu_rd_rsp   (lsu_rd_rsp),
    .lsu_wr_req   (lsu_wr_req),
    .lsu_wr_rsp   (lsu_wr_rsp),
    .sram_rd_req  (sram_rd_req),
    .uart_rd_req  (uart_rd_req),
    .clint_rd_req (clint_rd_req),
    .sram_wr_req  (sram_wr_req),
    .uart_wr_req  (uart_wr_req),
    .clint_wr_req (clint_wr_req)
);

// File: testbench/soc_bus_tb.sv
`timescale 1ns/1ps

module soc_bus_tb
    import soc_bus_pkg::*;
();

    localparam int SRAM_AW = 10;
    localparam int TIMEOUT = 200;
    localparam int N_WORDS = 32;

    typedef struct packed {
        data_t data;
        resp_t resp;
        logic  chk_data; // clear when the data cannot be predicted
    } expect_t;

    typedef struct packed {
        logic    is_wr;
        addr_t   addr;
        expect_t exp;
        data_t   got_data;
        resp_t   got_resp;
    } result_t;

    logic       clk;
    logic       rst;
    rd_req_t    ifu_rd_req;
    rd_rsp_t    ifu_rd_rsp;
    rd_req_t    lsu_rd_req;
    rd_rsp_t    lsu_rd_rsp;
    wr_req_t    lsu_wr_req;
    wr_rsp_t    lsu_wr_rsp;
    logic [7:0] tx_data;
    logic       tx_valid;
    logic       tx_ready;

    data_t      sram_model [addr_t];
    result_t    results [$];
    logic [7:0] tx_seen [$];
    int         errors = 0;
    int         checks = 0;
    int         cycle = 0;
    data_t      rng = 32'd50;

    tb_clock_gen #(.PERIOD(40), .RESET_CYCLES(8)) u_clk_gen (.clk(clk), .rst(rst));

    soc_bus_top #(.SRAM_AW(SRAM_AW)) dut (
        .clk        (clk),
        .rst        (rst),
        .ifu_rd_req (ifu_rd_req),
        .ifu_rd_rsp (ifu_rd_rsp),
        .lsu_rd_req (lsu_rd_req),
        .lsu_rd_rsp (lsu_rd_rsp),
        .lsu_wr_req (lsu_wr_req),
        .lsu_wr_rsp (lsu_wr_rsp),
        .tx_data    (tx_data),
        .tx_valid   (tx_valid),
        .tx_ready   (tx_ready)
    );

    always @(posedge clk) cycle <= cycle + 1;

    // byte leaves on the edge after this sample
    always @(negedge clk) begin
        if (!rst && tx_valid && tx_ready) tx_seen.push_back(tx_data);
    end

    function automatic data_t xorshift32(input data_t x);
        data_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic slave_sel_t decode_addr(input addr_t addr);
        if (addr >= SRAM_BASE && addr < SRAM_BASE + (addr_t'(4) << SRAM_AW)) return SEL_SRAM;
        if (addr == UART_ADDR) return SEL_UART;
        if (addr == CLINT_MTIME_LO || addr == CLINT_MTIME_HI) return SEL_CLINT;
        return SEL_NONE;
    endfunction

    function automatic expect_t expect_read(input addr_t addr, input logic uart_busy);
        expect_t e;
        e = '{data: '0, resp: RESP_OKAY, chk_data: 1'b1};
        case (decode_addr(addr))
            SEL_SRAM: begin
                if (sram_model.exists(addr)) e.data = sram_model[addr];
                else e.chk_data = 1'b0;
            end
            SEL_UART:  e.data = {31'b0, uart_busy}; // status word
            SEL_CLINT: e.chk_data = 1'b0;           // mtime checked on its own
            default:   e.resp = RESP_DECERR;
        endcase
        return e;
    endfunction

    // also updates the memory model
    function automatic resp_t expect_write(input addr_t addr, input data_t data);
        case (decode_addr(addr))
            SEL_SRAM: begin
                sram_model[addr] = data;
                return RESP_OKAY;
            end
            SEL_UART:  return RESP_OKAY;
            SEL_CLINT: return RESP_SLVERR;
            default:   return RESP_DECERR;
        endcase
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, TIMEOUT);
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic read_word(input logic from_ifu, input addr_t addr, output data_t data,
                             output resp_t resp, output int done_at);
        rd_rsp_t rsp;
        int      n;
        @(posedge clk);
        #1;
        if (from_ifu) ifu_rd_req = {addr, 1'b1, 1'b1}; // araddr arvalid rready
        else lsu_rd_req = {addr, 1'b1, 1'b1};
        rsp = '0;
        n = 0;
        while (!rsp.arready) begin
            if (n == TIMEOUT) abort_on_timeout("arready");
            @(negedge clk);
            rsp = from_ifu ? ifu_rd_rsp : lsu_rd_rsp;
            n++;
        end
        @(posedge clk);
        #1;
        if (from_ifu) ifu_rd_req.arvalid = 1'b0;
        else lsu_rd_req.arvalid = 1'b0;
        rsp = '0;
        n = 0;
        while (!rsp.rvalid) begin
            if (n == TIMEOUT) abort_on_timeout("rvalid");
            @(negedge clk);
            rsp = from_ifu ? ifu_rd_rsp : lsu_rd_rsp;
            n++;
        end
        data = rsp.rdata;
        resp = rsp.rresp;
        done_at = cycle;
        @(posedge clk);
        #1;
        if (from_ifu) ifu_rd_req = '0;
        else lsu_rd_req = '0;
    endtask

    task automatic write_word(input addr_t addr, input data_t data, output resp_t resp);
        wr_rsp_t rsp;
        int      n;
        @(posedge clk);
        #1;
        lsu_wr_req = {addr, 1'b1, data, 1'b1, 1'b1}; // awaddr awvalid wdata wvalid bready
        rsp = '0;
        n = 0;
        while (!(rsp.awready && rsp.wready)) begin
            if (n == TIMEOUT) abort_on_timeout("awready");
            @(negedge clk);
            rsp = lsu_wr_rsp;
            n++;
        end
        @(posedge clk);
        #1;
        lsu_wr_req.awvalid = 1'b0;
        lsu_wr_req.wvalid = 1'b0;
        rsp = '0;
        n = 0;
        while (!rsp.bvalid) begin
            if (n == TIMEOUT) abort_on_timeout("bvalid");
            @(negedge clk);
            rsp = lsu_wr_rsp;
            n++;
        end
        resp = rsp.bresp;
        @(posedge clk);
        #1;
        lsu_wr_req = '0;
    endtask

    task automatic read_checked(input logic from_ifu, input addr_t addr, input logic uart_busy,
                                output data_t data, output int done_at);
        expect_t e;
        resp_t   resp;
        e = expect_read(addr, uart_busy);
        read_word(from_ifu, addr, data, resp, done_at);
        results.push_back({1'b0, addr, e, data, resp});
    endtask

    task automatic write_checked(input addr_t addr, input data_t data);
        expect_t e;
        resp_t   resp;
        e = '0;
        e.resp = expect_write(addr, data);
        write_word(addr, data, resp);
        results.push_back({1'b1, addr, e, 32'h0, resp});
    endtask

    always @(negedge clk) begin : compare_results
        result_t r;
        while (results.size() > 0) begin
            r = results.pop_front();
            checks++;
            if (r.got_resp !== r.exp.resp) begin
                $display("error: %s got %h expected %h at address %h",
                         r.is_wr ? "bresp" : "rresp", r.got_resp, r.exp.resp, r.addr);
                errors++;
            end
            if (!r.is_wr && r.exp.chk_data && r.got_data !== r.exp.data) begin
                $display("error: rdata got %h expected %h at address %h",
                         r.got_data, r.exp.data, r.addr);
                errors++;
            end
        end
    end

    initial begin : main
        addr_t      addrs [N_WORDS];
        data_t      d;
        data_t      d2;
        data_t      t1;
        data_t      t2;
        int         ifu_done;
        int         lsu_done;
        int         done;
        int         n;
        logic [7:0] b1;
        logic [7:0] b2;

        ifu_rd_req = '0;
        lsu_rd_req = '0;
        lsu_wr_req = '0;
        tx_ready = 1'b0;
        n = 0;
        while (rst !== 1'b0) begin
            if (n == TIMEOUT) abort_on_timeout("reset release");
            @(posedge clk);
            n++;
        end

        // random sram words written by the lsu and read back by both masters
        for (int i = 0; i < N_WORDS; i++) begin
            rng = xorshift32(rng);
            addrs[i] = SRAM_BASE | addr_t'({rng[SRAM_AW-1:0], 2'b00});
            rng = xorshift32(rng);
            write_checked(addrs[i], rng);
        end
        for (int i = 0; i < N_WORDS; i++) begin
            read_checked(1'b0, addrs[i], 1'b0, d, done);
            read_checked(1'b1, addrs[i], 1'b0, d, done);
        end

        // both masters ask in the same cycle
        fork
            read_checked(1'b1, addrs[1], 1'b0, d, ifu_done);
            read_checked(1'b0, addrs[2], 1'b0, d2, lsu_done);
        join
        checks++;
        if (ifu_done >= lsu_done) begin
            $display("arbitration failure: lsu read done at cycle %0d, ifu read at cycle %0d",
                     lsu_done, ifu_done);
            errors++;
        end

        // uart with tx_ready held low
        rng = xorshift32(rng);
        b1 = rng[7:0];
        write_checked(UART_ADDR, rng);
        read_checked(1'b0, UART_ADDR, 1'b1, d, done);
        rng = xorshift32(rng);
        b2 = rng[7:0];
        fork
            write_checked(UART_ADDR, rng);
            begin
                repeat (10) begin
                    @(negedge clk);
                    checks += 2;
                    if (lsu_wr_rsp.bvalid) begin
                        $display("back-pressure failure: bvalid arrived with a byte pending");
                        errors++;
                    end
                    if (tx_valid !== 1'b1) begin
                        $display("error: tx_valid got %h expected 1", tx_valid);
                        errors++;
                    end
                end
                @(posedge clk);
                #1;
                tx_ready = 1'b1;
            end
        join
        n = 0;
        while (tx_seen.size() < 2) begin
            if (n == TIMEOUT) abort_on_timeout("uart byte");
            @(posedge clk);
            n++;
        end
        checks += 2;
        if (tx_seen[0] !== b1) begin
            $display("error: tx_data got %h expected %h", tx_seen[0], b1);
            errors++;
        end
        if (tx_seen[1] !== b2) begin
            $display("error: tx_data got %h expected %h", tx_seen[1], b2);
            errors++;
        end
        read_checked(1'b0, UART_ADDR, 1'b0, d, done); // idle again
        checks++;
        if (tx_seen.size() != 2) begin
            $display("uart sent %0d bytes where 2 were written", tx_seen.size());
            errors++;
        end

        // mtime moves forward and writes are refused
        read_checked(1'b0, CLINT_MTIME_LO, 1'b0, t1, done);
        read_checked(1'b0, CLINT_MTIME_LO, 1'b0, t2, done);
        checks++;
        if (t2 <= t1) begin
            $display("error: rdata got %h expected more than %h", t2, t1);
            errors++;
        end
        write_checked(CLINT_MTIME_LO, 32'h0);

        // unmapped address followed by a normal access
        read_checked(1'b0, 32'h1000_0000, 1'b0, d, done);
        write_checked(32'h1000_0000, rng);
        read_checked(1'b0, addrs[0], 1'b0, d, done);

        repeat (2) @(posedge clk); // let the compare process drain
        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: sources.f
src/soc_bus_pkg.sv
src/bus_xbar.sv
src/sram_slave.sv
src/uart_tx_slave.sv
src/clint_timer.sv
src/soc_bus_top.sv
testbench/tb_clock_gen.sv
testbench/bus_checker.sv
testbench/soc_bus_tb.sv
